/* alu.sv */
`timescale 1ns/1ps

module alu (
  input  logic [mips16_pkg::word_w-1:0] a,
  input  logic [mips16_pkg::word_w-1:0] b,
  input  logic [2:0]                    alu_ctrl,
  output logic [mips16_pkg::word_w-1:0] result,
  output logic                          zero
);

  logic [mips16_pkg::word_w-1:0] shl;
  logic [mips16_pkg::word_w-1:0] a_rev;
  logic [mips16_pkg::word_w-1:0] shr_rev;
  logic [mips16_pkg::word_w-1:0] shr;

  barrel_shifter u_shl (
    .din(a), .shamt(b[3:0]), .dout(shl)
  );

  // right shift = left shift of the bit-reversed word
  assign a_rev = {<<{a}};

  barrel_shifter u_shr (
    .din(a_rev), .shamt(b[3:0]), .dout(shr_rev)
  );

  assign shr = {<<{shr_rev}};

  always_comb begin
    case (alu_ctrl)
      mips16_pkg::alu_add: result = a + b;
      mips16_pkg::alu_sub: result = a - b;
      mips16_pkg::alu_and: result = a & b;
      mips16_pkg::alu_or:  result = a | b;
      mips16_pkg::alu_slt: result = (a < b) ? 16'd1 : 16'd0;  // unsigned
      mips16_pkg::alu_mul: result = {8'd0, a[7:0]} * {8'd0, b[7:0]};
      mips16_pkg::alu_sll: result = shl;
      mips16_pkg::alu_srl: result = shr;
      default:             result = a + b;
    endcase
  end

  assign zero = (result == '0);

endmodule

/* barrel_shifter.sv */
`timescale 1ns/1ps

module barrel_shifter (
  input  logic [15:0] din,
  input  logic [3:0]  shamt,
  output logic [15:0] dout
);

  logic [15:0] st1;
  logic [15:0] st2;
  logic [15:0] st4;

  // log stages with zero fill from the right
  assign st1  = shamt[0] ? {din[14:0], 1'b0}  : din;
  assign st2  = shamt[1] ? {st1[13:0], 2'b00} : st1;
  assign st4  = shamt[2] ? {st2[11:0], 4'h0}  : st2;
  assign dout = shamt[3] ? {st4[7:0], 8'h00}  : st4;  // by 8

endmodule

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
  parameter int words = 256
) (
  input  logic                          clk,
  input  logic [mips16_pkg::word_w-1:0] addr,
  input  logic [mips16_pkg::word_w-1:0] wr_data,
  input  logic                          wr_en,
  input  logic                          rd_en,
  output logic [mips16_pkg::word_w-1:0] rd_data
);

  localparam int aw = $clog2(words);

  logic [mips16_pkg::word_w-1:0] mem [words];
  logic [aw-1:0] word_addr;

  assign word_addr = addr[aw:1];  // byte address to word index

  initial begin
    for (int i = 0; i < words; i++)
      mem[i] = '0;
  end

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[word_addr] <= wr_data;
  end

  assign rd_data = rd_en ? mem[word_addr] : '0;

  a_rd_wr_excl: assert property (
    @(posedge clk) !$isunknown({wr_en, rd_en}) |-> !(wr_en && rd_en)
  ) else $error("data memory read and write in the same cycle");

endmodule

/* list.f */
mips16_pkg.sv
barrel_shifter.sv
alu.sv
reg_file.sv
data_mem.sv
pc_unit.sv
main_decoder.sv
mips16_top.sv
tb_mips16.sv

/* main_decoder.sv */
`timescale 1ns/1ps

module main_decoder (
  input  mips16_pkg::instr_t                instr,
  output logic [mips16_pkg::reg_addr_w-1:0] rs_addr,
  output logic [mips16_pkg::reg_addr_w-1:0] rt_addr,
  output logic [mips16_pkg::reg_addr_w-1:0] wr_addr,
  output logic [mips16_pkg::word_w-1:0]     imm_ext,
  output logic [mips16_pkg::word_w-1:0]     jump_target,
  output logic [2:0]                        alu_ctrl,
  output logic                              alu_src,
  output logic                              reg_write,
  output logic                              mem_read,
  output logic                              mem_write,
  output logic                              branch,
  output logic                              jump,
  output logic                              jr_sel,
  output logic                              link
);

  logic r_type;
  logic zero_ext;
  logic [2:0] funct_op;

  // opcode to control set
  always_comb begin
    r_type    = 1'b0;
    zero_ext  = 1'b0;
    alu_src   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    branch    = 1'b0;
    jump      = 1'b0;
    link      = 1'b0;
    alu_ctrl  = mips16_pkg::alu_add;
    case (instr.r.opcode)
      mips16_pkg::op_add_r: begin
        r_type    = 1'b1;
        reg_write = 1'b1;
        alu_ctrl  = funct_op;
      end
      mips16_pkg::op_slti: begin
        zero_ext  = 1'b1;  // imm compares as unsigned
        alu_src   = 1'b1;
        reg_write = 1'b1;
        alu_ctrl  = mips16_pkg::alu_slt;
      end
      mips16_pkg::op_j: jump = 1'b1;
      mips16_pkg::op_jal: begin
        jump      = 1'b1;
        link      = 1'b1;
        reg_write = 1'b1;  // r7 <= pc+2
      end
      mips16_pkg::op_lw: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
        mem_read  = 1'b1;
      end
      mips16_pkg::op_sw: begin
        alu_src   = 1'b1;
        mem_write = 1'b1;
      end
      mips16_pkg::op_beq: begin
        branch   = 1'b1;
        alu_ctrl = mips16_pkg::alu_sub;
      end
      mips16_pkg::op_addi: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      default: ;
    endcase
  end

  // R-type funct to ALU op
  always_comb begin
    case (instr.r.funct)
      mips16_pkg::fn_sub: funct_op = mips16_pkg::alu_sub;
      mips16_pkg::fn_and: funct_op = mips16_pkg::alu_and;
      mips16_pkg::fn_or:  funct_op = mips16_pkg::alu_or;
      mips16_pkg::fn_slt: funct_op = mips16_pkg::alu_slt;
      mips16_pkg::fn_mul: funct_op = mips16_pkg::alu_mul;
      mips16_pkg::fn_sll: funct_op = mips16_pkg::alu_sll;
      mips16_pkg::fn_srl: funct_op = mips16_pkg::alu_srl;
      default:            funct_op = mips16_pkg::alu_add;  // fn_add and up
    endcase
  end

  assign jr_sel = r_type && (instr.r.funct == mips16_pkg::fn_jr);

  assign rs_addr = instr.r.rs;
  assign rt_addr = instr.r.rt;
  // jal links to r7 and jr still writes its rd
  assign wr_addr = link ? 3'd7 : (r_type ? instr.r.rd : instr.r.rt);

  assign imm_ext = zero_ext ? {9'd0, instr.i.imm} : {{9{instr.i.imm[6]}}, instr.i.imm};

  // 13-bit target as a byte address with region bits added in pc_unit
  assign jump_target = {2'b00, instr.i.rs, instr.i.rt, instr.i.imm, 1'b0};

endmodule

/* mips16_pkg.sv */
package mips16_pkg;

  localparam int word_w     = 16;  // data and address width
  localparam int reg_addr_w = 3;   // eight registers

  // opcodes in bits [15:13]
  localparam logic [2:0] op_add_r = 3'd0;
  localparam logic [2:0] op_slti  = 3'd1;
  localparam logic [2:0] op_j     = 3'd2;
  localparam logic [2:0] op_jal   = 3'd3;
  localparam logic [2:0] op_lw    = 3'd4;
  localparam logic [2:0] op_sw    = 3'd5;
  localparam logic [2:0] op_beq   = 3'd6;
  localparam logic [2:0] op_addi  = 3'd7;

  // R-type funct codes in bits [3:0]
  localparam logic [3:0] fn_add = 4'd0;
  localparam logic [3:0] fn_sub = 4'd1;
  localparam logic [3:0] fn_and = 4'd2;
  localparam logic [3:0] fn_or  = 4'd3;
  localparam logic [3:0] fn_slt = 4'd4;
  localparam logic [3:0] fn_mul = 4'd5;
  localparam logic [3:0] fn_sll = 4'd6;
  localparam logic [3:0] fn_srl = 4'd7;
  localparam logic [3:0] fn_jr  = 4'd8;  // jump register with target in rs

  // ALU operations
  localparam logic [2:0] alu_add = 3'd0;
  localparam logic [2:0] alu_sub = 3'd1;
  localparam logic [2:0] alu_and = 3'd2;
  localparam logic [2:0] alu_or  = 3'd3;
  localparam logic [2:0] alu_slt = 3'd4;  // unsigned compare
  localparam logic [2:0] alu_mul = 3'd5;  // low bytes only
  localparam logic [2:0] alu_sll = 3'd6;
  localparam logic [2:0] alu_srl = 3'd7;

  // register format
  typedef struct packed {
    logic [2:0]            opcode;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [reg_addr_w-1:0] rd;
    logic [3:0]            funct;
  } r_fmt_t;

  // immediate format whose rs, rt and imm also form the 13-bit jump target
  typedef struct packed {
    logic [2:0]            opcode;
    logic [reg_addr_w-1:0] rs;
    logic [reg_addr_w-1:0] rt;
    logic [6:0]            imm;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_t;

endpackage

/* mips16_tests.txt */
# P lines give byte address and instruction word in hex
# E lines give pc and alu_result for each cycle after reset
P 00 e085  # addi r1, r0, 5
P 02 e17d  # addi r2, r0, -3
P 04 0530  # add  r3, r1, r2
P 06 0541  # sub  r4, r1, r2
P 08 0a52  # and  r5, r2, r4
P 0a 0653  # or   r5, r1, r4
P 0c 0564  # slt  r6, r1, r2
P 0e 0ae5  # mul  r6, r2, r5
P 10 e381  # addi r7, r0, 1
P 12 1bb6  # sll  r3, r6, r7
P 14 0bb7  # srl  r3, r2, r7
P 16 e387  # addi r7, r0, 7
P 18 0bb6  # sll  r3, r2, r7
P 1a 1bb7  # srl  r3, r6, r7
P 1c e38f  # addi r7, r0, 15
P 1e 07b6  # sll  r3, r1, r7
P 20 0bb7  # srl  r3, r2, r7
P 22 1836  # sll  r3, r6, r0
P 24 29ff  # slti r3, r2, 0x7f
P 26 25ff  # slti r3, r1, 0x7f
P 28 a704  # sw   r6, 4(r1)
P 2a 8388  # lw   r7, 8(r0)
P 2c 1c30  # add  r3, r7, r0
P 2e c085  # beq  r0, r1, +5
P 30 c481  # beq  r1, r1, +1
P 32 401e  # j    0x3c
P 34 c07e  # beq  r0, r0, -2
P 36 e009  # addi r0, r0, 9
P 38 1c30  # add  r3, r7, r0
P 3a 1c08  # jr   r7
P 3c 601b  # jal  0x36
P 3e 00c0  # add  r4, r0, r1
E 0000 0005
E 0002 fffd
E 0004 0002
E 0006 0008
E 0008 0008
E 000a 000d
E 000c 0001
E 000e 0cd9  # 0xfd * 0x0d
E 0010 0001
E 0012 19b2
E 0014 7ffe
E 0016 0007
E 0018 fe80
E 001a 0019
E 001c 000f
E 001e 8000
E 0020 0001
E 0022 0cd9
E 0024 0000  # imm zero extended
E 0026 0001
E 0028 0009  # word 4
E 002a 0008  # word 4 again
E 002c 0cd9
E 002e fffb  # not taken
E 0030 0000  # taken forward
E 0034 0000  # taken backward
E 0032 0000
E 003c 0000
E 0036 0009
E 0038 003e  # r7 holds link, r0 still zero
E 003a 003e
E 003e 0005

/* mips16_top.sv */
`timescale 1ns/1ps

module mips16_top #(
  parameter int dmem_words = 256
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [mips16_pkg::word_w-1:0] instr,
  output logic [mips16_pkg::word_w-1:0] pc,
  output logic [mips16_pkg::word_w-1:0] alu_result
);

  logic [mips16_pkg::word_w-1:0]     pc_plus2;
  logic [mips16_pkg::reg_addr_w-1:0] rs_addr;
  logic [mips16_pkg::reg_addr_w-1:0] rt_addr;
  logic [mips16_pkg::reg_addr_w-1:0] wr_addr;
  logic [mips16_pkg::word_w-1:0]     imm_ext;
  logic [mips16_pkg::word_w-1:0]     jump_target;
  logic [2:0]                        alu_ctrl;
  logic alu_src, reg_write, mem_read, mem_write;
  logic branch, jump, jr_sel, link;
  logic [mips16_pkg::word_w-1:0]     rd_data_1;
  logic [mips16_pkg::word_w-1:0]     rd_data_2;
  logic [mips16_pkg::word_w-1:0]     alu_b;
  logic                              zero;
  logic [mips16_pkg::word_w-1:0]     mem_rd_data;
  logic [mips16_pkg::word_w-1:0]     wr_data;
  logic [mips16_pkg::word_w-1:0]     branch_offset;
  logic                              branch_taken;

  main_decoder u_dec (
    .instr(instr), .rs_addr(rs_addr), .rt_addr(rt_addr), .wr_addr(wr_addr),
    .imm_ext(imm_ext), .jump_target(jump_target), .alu_ctrl(alu_ctrl),
    .alu_src(alu_src), .reg_write(reg_write), .mem_read(mem_read),
    .mem_write(mem_write), .branch(branch), .jump(jump), .jr_sel(jr_sel),
    .link(link)
  );

  reg_file u_regs (
    .clk(clk), .reset(reset), .wr_en(reg_write), .wr_addr(wr_addr),
    .wr_data(wr_data), .rd_addr_1(rs_addr), .rd_data_1(rd_data_1),
    .rd_addr_2(rt_addr), .rd_data_2(rd_data_2)
  );

  assign alu_b = alu_src ? imm_ext : rd_data_2;  // immediate or rt

  alu u_alu (
    .a(rd_data_1), .b(alu_b), .alu_ctrl(alu_ctrl), .result(alu_result), .zero(zero)
  );

  data_mem #(.words(dmem_words)) u_dmem (
    .clk(clk), .addr(alu_result), .wr_data(rd_data_2), .wr_en(mem_write),
    .rd_en(mem_read), .rd_data(mem_rd_data)
  );

  // writeback of return address, load data or ALU result
  always_comb begin
    if (link)
      wr_data = pc_plus2;
    else if (mem_read)
      wr_data = mem_rd_data;
    else
      wr_data = alu_result;
  end

  assign branch_taken  = branch & zero;  // beq compares by subtract
  assign branch_offset = {imm_ext[mips16_pkg::word_w-2:0], 1'b0};

  pc_unit u_pc (
    .clk(clk), .reset(reset), .jump(jump), .jr_sel(jr_sel),
    .branch_taken(branch_taken), .jump_target(jump_target),
    .branch_offset(branch_offset), .jr_addr(rd_data_1),
    .pc(pc), .pc_plus2(pc_plus2)
  );

endmodule

/* pc_unit.sv */
`timescale 1ns/1ps

module pc_unit (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          jump,
  input  logic                          jr_sel,
  input  logic                          branch_taken,
  input  logic [mips16_pkg::word_w-1:0] jump_target,
  input  logic [mips16_pkg::word_w-1:0] branch_offset,
  input  logic [mips16_pkg::word_w-1:0] jr_addr,
  output logic [mips16_pkg::word_w-1:0] pc,
  output logic [mips16_pkg::word_w-1:0] pc_plus2
);

  // top two bits of the jump address come from pc+2
  localparam logic [mips16_pkg::word_w-1:0] region_mask =
    {2'b11, {(mips16_pkg::word_w-2){1'b0}}};

  logic [mips16_pkg::word_w-1:0] jump_pc;
  logic [mips16_pkg::word_w-1:0] pc_next;

  assign pc_plus2 = pc + mips16_pkg::word_w'(2);
  assign jump_pc  = (pc_plus2 & region_mask) | jump_target;

  // jr first, then j/jal, then taken beq
  always_comb begin
    if (jr_sel)
      pc_next = jr_addr;
    else if (jump)
      pc_next = jump_pc;
    else if (branch_taken)
      pc_next = pc_plus2 + branch_offset;  // offset already sign extended
    else
      pc_next = pc_plus2;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      pc <= '0;
    else
      pc <= pc_next;
  end

  // jumps never carry a branch compare
  a_no_jump_and_branch: assert property (
    @(posedge clk) disable iff (reset) !(jump && branch_taken)
  ) else $error("jump and taken branch in the same cycle");

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              wr_en,
  input  logic [mips16_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [mips16_pkg::word_w-1:0]     wr_data,
  input  logic [mips16_pkg::reg_addr_w-1:0] rd_addr_1,
  output logic [mips16_pkg::word_w-1:0]     rd_data_1,
  input  logic [mips16_pkg::reg_addr_w-1:0] rd_addr_2,
  output logic [mips16_pkg::word_w-1:0]     rd_data_2
);

  logic [mips16_pkg::word_w-1:0] regs [2**mips16_pkg::reg_addr_w];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**mips16_pkg::reg_addr_w; i++)
        regs[i] <= '0;
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;  // r0 may be written but reads mask it
    end
  end

  assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];
  assign rd_data_2 = (rd_addr_2 == '0) ? '0 : regs[rd_addr_2];

  // no unknown values reach the datapath once out of reset
  a_rd_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown({rd_data_1, rd_data_2})
  ) else $error("register read returned X");

endmodule

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mips16 -f list.f -o tb_mips16 ||
  { echo "verilator build failed"; exit 1; }
./obj_dir/tb_mips16 > sim.log 2>&1 || echo "simulation exited with an error"
cat sim.log
grep -q "^TEST OK$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }

/* tb_mips16.sv */
`timescale 1ns/1ps

module tb_mips16;

  localparam int prog_words = 32;   // instruction memory served by the testbench
  localparam int max_steps  = 256;  // room for expected trace entries

  logic               clk;
  logic               reset;
  mips16_pkg::instr_t instr;
  logic [15:0]        pc;
  logic [15:0]        alu_result;

  logic [15:0] prog    [prog_words];
  logic [15:0] exp_pc  [max_steps];
  logic [15:0] exp_alu [max_steps];

  int n_trace;
  int step;
  int cycle_limit;
  int cycles;

  mips16_top #(.dmem_words(256)) UUT (
    .clk(clk),
    .reset(reset),
    .instr(instr),
    .pc(pc),
    .alu_result(alu_result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // instruction memory model where unloaded or odd addresses read as 0
  function automatic logic [15:0] fetch_word(input logic [15:0] addr);
    if (addr < 16'(2 * prog_words) && !addr[0])
      return prog[addr[5:1]];
    return 16'h0000;
  endfunction

  // P lines fill the program and E lines build the expected trace
  task automatic load_tests();
    int          fd;
    int          code;
    int          i;
    string       line;
    logic [7:0]  tag;
    logic [15:0] f1;
    logic [15:0] f2;
    fd = $fopen("mips16_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open mips16_tests.txt");
      $display("TEST FAILED");
      $fatal(1, "missing stimulus file");
    end else begin
      for (i = 0; i < prog_words; i++)
        prog[i] = 16'h0000;
      n_trace = 0;
      while ($fgets(line, fd) != 0) begin
        code = $sscanf(line, "%c %h %h", tag, f1, f2);
        if (code == 3 && tag == "P" && f1 < 16'(2 * prog_words)) begin
          prog[f1[5:1]] = f2;
        end else if (code == 3 && tag == "E" && n_trace < max_steps) begin
          exp_pc[n_trace]  = f1;
          exp_alu[n_trace] = f2;
          n_trace++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_word(input string name, input logic [15:0] got,
                            input logic [15:0] expected);
    assert (got === expected) else begin
      $display("FAILED %s: got %h, expected %h (step %0d, opcode %0d)",
               name, got, expected, step, instr.r.opcode);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  initial begin
    reset       = 1'b1;
    instr       = '0;
    step        = 0;
    cycle_limit = 0;
    load_tests();
    cycle_limit = n_trace + 20;

    repeat (4) @(negedge clk);  // reset held 4 cycles
    reset = 1'b0;

    // one instruction per cycle
    for (step = 0; step < n_trace; step++) begin
      instr = fetch_word(pc);
      #2;
      check_word("pc", pc, exp_pc[step]);
      check_word("alu_result", alu_result, exp_alu[step]);
      @(negedge clk);
    end

    if (n_trace == 0) begin
      $display("no expected trace entries found in mips16_tests.txt");
      $display("TEST FAILED");
      $fatal(1, "empty trace");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  // watchdog sized from the trace length
  initial begin
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the trace did not finish within %0d cycles", cycles);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule
